// File: Makefile
# Verilator build and run for the return address predictor

LOG := sim.log

.PHONY: all lint clean

# build the testbench, run it and search the log for the pass line
all:
	verilator --binary --timing -f fetchRet.f --top-module fetchRet_tb -o simv
	./obj_dir/simv | tee $(LOG)
	grep -qx "TEST PASS" $(LOG)

# lint the RTL top level
lint:
	verilator --lint-only --timing -Wall -f fetchRet.f --top-module fetchRet

clean:
	rm -rf obj_dir $(LOG)

// File: bench/fetchRet_tb.sv
`timescale 1ns/1ps
`include "fetchRet_cfg.svh"

module fetchRet_tb;
    import fetchRetPkg::*;

    localparam int kindFetch = 0;
    localparam int kindResolve = 1;
    localparam int kindCommit = 2;
    localparam int maxRows = 64;
    localparam int idCount = 1 << $bits(FetchId);

    logic   clk;
    logic   rst;
    logic   fetchValid;
    FetchPc fetchPc;
    logic   fetchIsCall;
    logic   fetchIsRet;
    logic   fetchReady;
    FetchId commitId;
    logic   resolveValid;
    FetchId resolveId;
    FetchPc resolveTarget;
    logic   predValid;
    FetchPc predAddr;
    FetchId predId;
    logic   misprValid;
    logic   stall;

    // one row per step; rowId is the fetch ID, the resolved ID or the commit ID
    int     rowKind [maxRows];
    FetchPc rowAddr [maxRows];
    logic   rowCall [maxRows];
    logic   rowRet [maxRows];
    logic   rowChain [maxRows];
    FetchId rowId [maxRows];
    FetchPc rowExp [maxRows];
    logic   rowMispr [maxRows];
    int     rowCount;

    // reference stack, plus a copy of it taken before every return
    FetchPc modelMem [`RS_DEPTH];
    int     modelIdx;
    FetchId nextId;
    FetchPc snapMem [idCount][`RS_DEPTH];
    int     snapIdx [idCount];
    FetchPc predOf [idCount];

    int   errorCount;
    int   checkCount;
    logic chained;

    fetchRet fetchRet_inst (
        .clk           (clk),
        .rst           (rst),
        .fetchValid    (fetchValid),
        .fetchPc       (fetchPc),
        .fetchIsCall   (fetchIsCall),
        .fetchIsRet    (fetchIsRet),
        .fetchReady    (fetchReady),
        .commitId      (commitId),
        .resolveValid  (resolveValid),
        .resolveId     (resolveId),
        .resolveTarget (resolveTarget),
        .predValid     (predValid),
        .predAddr      (predAddr),
        .predId        (predId),
        .misprValid    (misprValid),
        .stall         (stall)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic FetchPc randomPc();
        return FetchPc'($urandom);
    endfunction

    task automatic newRow(input int kind);
        rowKind[rowCount] = kind;
        rowAddr[rowCount] = '0;
        rowCall[rowCount] = 1'b0;
        rowRet[rowCount] = 1'b0;
        rowChain[rowCount] = 1'b0;
        rowId[rowCount] = '0;
        rowExp[rowCount] = '0;
        rowMispr[rowCount] = 1'b0;
    endtask

    task automatic addCall(input FetchPc pc, input logic chain);
        newRow(kindFetch);
        rowAddr[rowCount] = pc;
        rowCall[rowCount] = 1'b1;
        rowChain[rowCount] = chain;
        rowId[rowCount] = nextId;
        // the return address is the next halfword
        modelIdx = (modelIdx + 1) % `RS_DEPTH;
        modelMem[modelIdx] = pc + 31'd1;
        nextId = nextId + 1'b1;
        rowCount++;
    endtask

    task automatic addRet(output FetchId id);
        newRow(kindFetch);
        rowAddr[rowCount] = randomPc();
        rowRet[rowCount] = 1'b1;
        rowId[rowCount] = nextId;
        id = nextId;
        for (int k = 0; k < `RS_DEPTH; k++) begin
            snapMem[nextId][k] = modelMem[k];
        end
        snapIdx[nextId] = modelIdx;
        rowExp[rowCount] = modelMem[modelIdx];
        predOf[nextId] = modelMem[modelIdx];
        modelIdx = (modelIdx + `RS_DEPTH - 1) % `RS_DEPTH;
        nextId = nextId + 1'b1;
        rowCount++;
    endtask

    task automatic addResolve(input FetchId id, input FetchPc target);
        newRow(kindResolve);
        rowId[rowCount] = id;
        rowAddr[rowCount] = target;
        rowMispr[rowCount] = (target != predOf[id]);
        // a wrong target puts the stack back as it was before that return
        if (rowMispr[rowCount]) begin
            for (int k = 0; k < `RS_DEPTH; k++) begin
                modelMem[k] = snapMem[id][k];
            end
            modelIdx = snapIdx[id];
        end
        rowCount++;
    endtask

    task automatic addCommit(input FetchId id);
        newRow(kindCommit);
        rowId[rowCount] = id;
        rowCount++;
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("mismatch %s got %h expected %h", name, got, exp);
        errorCount++;
    endtask

    task automatic applyFetch(input int r);
        int n;
        n = 0;
        while (!chained && !fetchReady && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!fetchReady) begin
            $display("timeout waiting for fetchReady");
            errorCount++;
        end
        @(posedge clk);
        fetchValid <= 1'b1;
        fetchPc <= rowAddr[r];
        fetchIsCall <= rowCall[r];
        fetchIsRet <= rowRet[r];
        // a chained row goes out in the very next cycle
        chained = rowChain[r];
        if (!chained) begin
            @(posedge clk);
            fetchValid <= 1'b0;
            @(negedge clk);
            if (rowRet[r]) begin
                n = 0;
                while (!predValid && n < 8) begin
                    @(negedge clk);
                    n++;
                end
                checkCount++;
                if (!predValid) begin
                    $display("timeout waiting for predValid, row %0d", r);
                    errorCount++;
                end else begin
                    // the prediction is due two cycles after acceptance
                    if (n != 1) begin
                        $display("predValid came %0d cycles after acceptance instead of 2, row %0d",
                                 n + 1, r);
                        errorCount++;
                    end
                    if (predAddr != rowExp[r]) begin
                        reportMismatch("predAddr", 32'(predAddr), 32'(rowExp[r]));
                    end
                    if (predId != rowId[r]) begin
                        reportMismatch("predId", 32'(predId), 32'(rowId[r]));
                    end
                end
            end
        end
    endtask

    task automatic applyResolve(input int r);
        int n;
        @(posedge clk);
        resolveValid <= 1'b1;
        resolveId <= rowId[r];
        resolveTarget <= rowAddr[r];
        @(posedge clk);
        resolveValid <= 1'b0;
        @(negedge clk);
        n = 0;
        while (!misprValid && n < 4) begin
            @(negedge clk);
            n++;
        end
        checkCount++;
        if (misprValid != rowMispr[r]) begin
            reportMismatch("misprValid", 32'(misprValid), 32'(rowMispr[r]));
        end
        if (misprValid) begin
            // a mispredict is due one cycle after the resolve
            if (n != 0) begin
                $display("misprValid came %0d cycles after the resolve instead of 1", n + 1);
                errorCount++;
            end
            @(negedge clk);
            if (!stall) begin
                $display("stall did not rise after the mispredict");
                errorCount++;
            end
            n = 0;
            while (stall && n < 16) begin
                checkCount++;
                if (fetchReady) begin
                    reportMismatch("fetchReady", 32'(fetchReady), 32'd0);
                end
                @(negedge clk);
                n++;
            end
            if (stall) begin
                $display("timeout waiting for stall to fall");
                errorCount++;
            end
        end
    endtask

    task automatic applyCommit(input int r);
        @(posedge clk);
        commitId <= rowId[r];
        @(negedge clk);
    endtask

    initial begin
        FetchId retId;
        FetchId badId;
        int     i;
        void'($urandom(32'h3829_b82a));
        rst = 1'b1;
        fetchValid = 1'b0;
        fetchPc = '0;
        fetchIsCall = 1'b0;
        fetchIsRet = 1'b0;
        commitId = '0;
        resolveValid = 1'b0;
        resolveId = '0;
        resolveTarget = '0;
        errorCount = 0;
        checkCount = 0;
        chained = 1'b0;
        rowCount = 0;
        modelIdx = 0;
        nextId = '0;

        // call then return, then a return right behind its call
        addCall(randomPc(), 1'b0);
        addRet(retId);
        addCall(randomPc(), 1'b1);
        addRet(retId);
        addResolve(retId, predOf[retId]);
        // one call more than the stack holds, then unwind
        for (i = 0; i <= `RS_DEPTH; i++) begin
            addCall(randomPc(), 1'b0);
        end
        for (i = 0; i <= `RS_DEPTH; i++) begin
            addRet(retId);
        end
        addResolve(retId, predOf[retId]);
        // two wrong-path returns behind a mispredicted one
        addCall(randomPc(), 1'b0);
        addCall(randomPc(), 1'b0);
        addRet(badId);
        addRet(retId);
        addRet(retId);
        addResolve(badId, ~predOf[badId]);
        addRet(retId);
        addRet(retId);
        // mispredict after the older return has committed
        addCall(randomPc(), 1'b0);
        addRet(retId);
        addResolve(retId, predOf[retId]);
        addCommit(nextId);
        addCall(randomPc(), 1'b0);
        addRet(badId);
        addRet(retId);
        addResolve(badId, ~predOf[badId]);
        addRet(retId);
        addRet(retId);

        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkCount++;
        if (fetchReady !== 1'b1) begin
            reportMismatch("fetchReady", 32'(fetchReady), 32'd1);
        end
        if (predValid !== 1'b0) begin
            reportMismatch("predValid", 32'(predValid), 32'd0);
        end
        if (misprValid !== 1'b0) begin
            reportMismatch("misprValid", 32'(misprValid), 32'd0);
        end
        if (stall !== 1'b0) begin
            reportMismatch("stall", 32'(stall), 32'd0);
        end

        for (i = 0; i < rowCount; i++) begin
            case (rowKind[i])
                kindFetch: applyFetch(i);
                kindResolve: applyResolve(i);
                default: applyCommit(i);
            endcase
        end

        $display("checks %0d errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: common/fetchRetPkg.sv
`include "fetchRet_cfg.svh"

package fetchRetPkg;

    // halfword address
    typedef logic [30:0] FetchPc;

    // wraps, so order is only meaningful relative to some base
    typedef logic [4:0] FetchId;

    typedef logic [$clog2(`RS_DEPTH)-1:0] StackIdx;
    typedef logic [$clog2(`RRQ_DEPTH)-1:0] QueueIdx;
    typedef logic [$clog2(`PEND_DEPTH)-1:0] PendSlot;

    typedef enum logic {
        recIdle,
        recRestore
    } RecoverState;

endpackage

// File: common/fetchRet_cfg.svh
`ifndef FETCHRET_CFG_SVH
`define FETCHRET_CFG_SVH

// return stack entries
`define RS_DEPTH 4

// recovery queue entries, one slot stays free to tell full from empty
`define RRQ_DEPTH 4

// outstanding return predictions held by the resolver
`define PEND_DEPTH 4

`endif

// File: fetchRet.f
+incdir+common
common/fetchRetPkg.sv
src/fetchCursor.sv
returnStack/returnStack.sv
src/returnResolver.sv
src/fetchRet.sv
bench/fetchRet_tb.sv

// File: returnStack/returnStack.sv
`timescale 1ns/1ps
`include "fetchRet_cfg.svh"

module returnStack (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 brValid,
    input  fetchRetPkg::FetchPc  brPc,
    input  logic                 brIsCall,
    input  logic                 brIsRet,
    input  fetchRetPkg::FetchId  brId,
    input  fetchRetPkg::FetchId  commitId,
    input  logic                 misprValid,
    input  fetchRetPkg::FetchId  misprId,
    input  fetchRetPkg::StackIdx misprIdx,
    output logic                 stall,
    output logic                 predValid,
    output fetchRetPkg::FetchPc  predAddr,
    output fetchRetPkg::FetchId  predId,
    output fetchRetPkg::StackIdx predIdx
);
    import fetchRetPkg::*;

    FetchPc  stackMem [`RS_DEPTH];
    StackIdx idxReg;
    StackIdx stackIdx;

    // a call's return address reaches the array one cycle after the call
    logic    pushValid;
    StackIdx pushIdx;
    FetchPc  pushAddr;

    // recovery queue, head is the next free slot and tail the oldest entry
    FetchId  qId [`RRQ_DEPTH];
    StackIdx qIdx [`RRQ_DEPTH];
    FetchPc  qAddr [`RRQ_DEPTH];
    QueueIdx qHead;
    QueueIdx qTail;
    QueueIdx headPrev;
    QueueIdx headNext;

    RecoverState recState;
    FetchId      recoveryId;
    FetchId      recoveryBase;
    FetchId      lastCommitId;

    logic   brTake;
    logic   doCall;
    logic   doRet;
    FetchPc topAddr;
    FetchId headAge;
    FetchId recoveryAge;
    FetchId tailAge;
    FetchId commitAge;
    logic   queueEmpty;
    logic   restoreHit;
    logic   restoreStep;
    logic   commitHit;
    logic   overwrite;

    // branches are dropped while recovering, they belong to the wrong path
    assign brTake = brValid && !misprValid && (recState == recIdle);
    assign doCall = brTake && brIsCall;
    assign doRet = brTake && brIsRet && !brIsCall;

    assign stall = (recState == recRestore);

    assign headPrev = qHead - 1'b1;
    assign headNext = qHead + 1'b1;
    assign queueEmpty = (qHead == qTail);

    // the mispredict index takes effect in the same cycle
    always_comb begin
        stackIdx = idxReg;
        if (misprValid) begin
            stackIdx = misprIdx;
        end else if (doCall) begin
            stackIdx = idxReg + 1'b1;
        end else if (doRet) begin
            stackIdx = idxReg - 1'b1;
        end
    end

    // return right behind a call sees the address before it is written
    assign topAddr = (pushValid && pushIdx == idxReg) ? pushAddr : stackMem[idxReg];

    // all ID ordering is done as distance from a base
    assign headAge = qId[headPrev] - recoveryBase;
    assign recoveryAge = recoveryId - recoveryBase;
    assign restoreHit = !queueEmpty && (headAge >= recoveryAge);
    assign restoreStep = (recState == recRestore) && !misprValid && restoreHit;

    assign tailAge = qId[qTail] - lastCommitId;
    assign commitAge = commitId - lastCommitId;
    assign commitHit = !queueEmpty && (tailAge < commitAge);

    // full queue drops its oldest backup, committed or not
    assign overwrite = doRet && (headNext == qTail);

    always_ff @(posedge clk) begin
        if (rst) begin
            idxReg <= '0;
            pushValid <= 1'b0;
            predValid <= 1'b0;
            qHead <= '0;
            qTail <= '0;
            recState <= recIdle;
            lastCommitId <= '0;
        end else begin
            idxReg <= stackIdx;
            pushValid <= doCall;
            predValid <= doRet;

            if (misprValid) begin
                recState <= recRestore;
            end else if (recState == recRestore) begin
                // walk down from the head, stop at the first older entry
                if (restoreHit) begin
                    qHead <= headPrev;
                end else begin
                    recState <= recIdle;
                end
            end else begin
                if (doRet) begin
                    qHead <= headNext;
                end
                if (overwrite || commitHit) begin
                    qTail <= qTail + 1'b1;
                end
                // one retirement per cycle, base catches up when nothing is left
                if (lastCommitId != commitId) begin
                    lastCommitId <= commitHit ? qId[qTail] : commitId;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pushValid) begin
            stackMem[pushIdx] <= pushAddr;
        end
        if (restoreStep) begin
            stackMem[qIdx[headPrev]] <= qAddr[headPrev];
        end

        if (doCall) begin
            pushIdx <= idxReg + 1'b1;
            pushAddr <= brPc + 31'd1;
        end

        if (doRet) begin
            // keep the popped entry so a mispredict can put it back
            qId[qHead] <= brId;
            qIdx[qHead] <= idxReg;
            qAddr[qHead] <= topAddr;

            predAddr <= topAddr;
            predId <= brId;
            predIdx <= idxReg;
        end

        if (misprValid) begin
            recoveryId <= misprId;
            recoveryBase <= lastCommitId;
        end
    end

endmodule

// File: src/fetchCursor.sv
`timescale 1ns/1ps

module fetchCursor (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                fetchValid,
    input  fetchRetPkg::FetchPc fetchPc,
    input  logic                fetchIsCall,
    input  logic                fetchIsRet,
    output logic                fetchReady,
    output logic                brValid,
    output fetchRetPkg::FetchPc brPc,
    output logic                brIsCall,
    output logic                brIsRet,
    output fetchRetPkg::FetchId brId
);
    import fetchRetPkg::*;

    // next ID to hand out, never rewound on a mispredict
    FetchId idCounter;
    logic   accept;

    assign fetchReady = !stall;
    assign accept = fetchValid && fetchReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            brValid <= 1'b0;
            idCounter <= '0;
        end else begin
            brValid <= accept;
            if (accept) begin
                idCounter <= idCounter + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            brPc <= fetchPc;
            brIsCall <= fetchIsCall;
            // call wins when a descriptor claims both
            brIsRet <= fetchIsRet && !fetchIsCall;
            brId <= idCounter;
        end
    end

endmodule

// File: src/fetchRet.sv
`timescale 1ns/1ps

module fetchRet (
    input  logic                clk,
    input  logic                rst,
    input  logic                fetchValid,
    input  fetchRetPkg::FetchPc fetchPc,
    input  logic                fetchIsCall,
    input  logic                fetchIsRet,
    output logic                fetchReady,
    input  fetchRetPkg::FetchId commitId,
    input  logic                resolveValid,
    input  fetchRetPkg::FetchId resolveId,
    input  fetchRetPkg::FetchPc resolveTarget,
    output logic                predValid,
    output fetchRetPkg::FetchPc predAddr,
    output fetchRetPkg::FetchId predId,
    output logic                misprValid,
    output logic                stall
);
    import fetchRetPkg::*;

    // fetch descriptors after the cursor
    logic    brValid;
    FetchPc  brPc;
    logic    brIsCall;
    logic    brIsRet;
    FetchId  brId;

    StackIdx predIdx;
    FetchId  misprId;
    StackIdx misprIdx;

    fetchCursor fetchCursor_inst (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .fetchValid  (fetchValid),
        .fetchPc     (fetchPc),
        .fetchIsCall (fetchIsCall),
        .fetchIsRet  (fetchIsRet),
        .fetchReady  (fetchReady),
        .brValid     (brValid),
        .brPc        (brPc),
        .brIsCall    (brIsCall),
        .brIsRet     (brIsRet),
        .brId        (brId)
    );

    returnStack returnStack_inst (
        .clk        (clk),
        .rst        (rst),
        .brValid    (brValid),
        .brPc       (brPc),
        .brIsCall   (brIsCall),
        .brIsRet    (brIsRet),
        .brId       (brId),
        .commitId   (commitId),
        .misprValid (misprValid),
        .misprId    (misprId),
        .misprIdx   (misprIdx),
        .stall      (stall),
        .predValid  (predValid),
        .predAddr   (predAddr),
        .predId     (predId),
        .predIdx    (predIdx)
    );

    returnResolver returnResolver_inst (
        .clk           (clk),
        .rst           (rst),
        .predValid     (predValid),
        .predAddr      (predAddr),
        .predId        (predId),
        .predIdx       (predIdx),
        .resolveValid  (resolveValid),
        .resolveId     (resolveId),
        .resolveTarget (resolveTarget),
        .misprValid    (misprValid),
        .misprId       (misprId),
        .misprIdx      (misprIdx)
    );

endmodule

// File: src/returnResolver.sv
`timescale 1ns/1ps
`include "fetchRet_cfg.svh"

module returnResolver (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 predValid,
    input  fetchRetPkg::FetchPc  predAddr,
    input  fetchRetPkg::FetchId  predId,
    input  fetchRetPkg::StackIdx predIdx,
    input  logic                 resolveValid,
    input  fetchRetPkg::FetchId  resolveId,
    input  fetchRetPkg::FetchPc  resolveTarget,
    output logic                 misprValid,
    output fetchRetPkg::FetchId  misprId,
    output fetchRetPkg::StackIdx misprIdx
);
    import fetchRetPkg::*;

    logic [`PEND_DEPTH-1:0] pendValid;
    FetchId  pendId [`PEND_DEPTH];
    FetchPc  pendAddr [`PEND_DEPTH];
    StackIdx pendIdx [`PEND_DEPTH];

    logic                   hit;
    PendSlot                hitSlot;
    logic                   wrongTarget;
    logic                   anyFree;
    PendSlot                freeSlot;
    PendSlot                oldSlot;
    FetchId                 oldAge;
    FetchId                 slotAge;
    FetchId                 slotDiff;
    FetchId                 predDiff;
    logic [`PEND_DEPTH-1:0] younger;
    logic                   insert;
    PendSlot                insertSlot;
    logic [`PEND_DEPTH-1:0] nextValid;

    always_comb begin
        hit = 1'b0;
        hitSlot = '0;
        anyFree = 1'b0;
        freeSlot = '0;
        oldSlot = '0;
        oldAge = '0;
        slotAge = '0;
        slotDiff = '0;
        younger = '0;

        // downward scan so the lowest free slot wins
        for (int i = `PEND_DEPTH - 1; i >= 0; i--) begin
            if (pendValid[i] && pendId[i] == resolveId) begin
                hit = 1'b1;
                hitSlot = PendSlot'(i);
            end
            if (!pendValid[i]) begin
                anyFree = 1'b1;
                freeSlot = PendSlot'(i);
            end
        end

        for (int i = 0; i < `PEND_DEPTH; i++) begin
            // oldest entry is the one furthest behind the incoming ID
            slotAge = predId - pendId[i];
            if (slotAge >= oldAge) begin
                oldAge = slotAge;
                oldSlot = PendSlot'(i);
            end
            // upper half of the ID range counts as older than the resolve
            slotDiff = pendId[i] - resolveId;
            younger[i] = !slotDiff[$bits(FetchId)-1];
        end

        wrongTarget = resolveValid && hit && (pendAddr[hitSlot] != resolveTarget);

        // a prediction arriving with the mispredict is on the wrong path too
        predDiff = predId - resolveId;
        insert = predValid && !(wrongTarget && !predDiff[$bits(FetchId)-1]);
        insertSlot = anyFree ? freeSlot : oldSlot;

        nextValid = pendValid;
        if (resolveValid && hit) begin
            nextValid[hitSlot] = 1'b0;
        end
        if (wrongTarget) begin
            nextValid = nextValid & ~younger;
        end
        if (insert) begin
            nextValid[insertSlot] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pendValid <= '0;
            misprValid <= 1'b0;
        end else begin
            pendValid <= nextValid;
            misprValid <= wrongTarget;
        end
    end

    always_ff @(posedge clk) begin
        if (insert) begin
            pendId[insertSlot] <= predId;
            pendAddr[insertSlot] <= predAddr;
            pendIdx[insertSlot] <= predIdx;
        end
        // stack index from before the pop lets the buffer rewind to it
        if (wrongTarget) begin
            misprId <= resolveId;
            misprIdx <= pendIdx[hitSlot];
        end
    end

endmodule
